// ==== Bender.yml ====
package:
  name: vcap_capture

export_include_dirs:
  - include

sources:
  - files:
      - src/vcap_pkg.sv
      - src/vcap_stream_if.sv
      - src/vcap_fifo.sv
      - src/video_stream_gen.sv
      - src/frame_capture.sv
      - src/axi_burst_writer.sv
      - src/vcap_top.sv
  - target: simulation
    files:
      - sim/tb_vcap_top.sv

// ==== include/vcap_defs.svh ====
`ifndef VCAP_DEFS_SVH
`define VCAP_DEFS_SVH

// Data path widths
`define VCAP_PIXEL_W 24
`define VCAP_WORD_W 32
`define VCAP_ADDR_W 32
`define VCAP_ID_W 4

// Words per full AXI burst
`define VCAP_BURST_LEN 16

// Buffering between capture and the AXI master
`define VCAP_DATA_DEPTH 64
`define VCAP_CMD_DEPTH 4

// Byte address of the first stored pixel
`define VCAP_FRAME_BASE 32'h0000_1000

`endif

// ==== sim/tb_vcap_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vcap_defs.svh"

module tb_vcap_top;
    import vcap_pkg::*;

    localparam int STIM_LINES  = 32;
    localparam int STIM_COLS   = 7;
    localparam int BURST_BYTES = `VCAP_BURST_LEN * (`VCAP_WORD_W / 8);
    localparam int MEM_WORDS   = 1024;
    localparam int MAX_BURSTS  = 128;
    localparam int DONE_LIMIT  = 5000;

    logic                      clk;
    logic                      rst_n_i;
    logic                      de_i;
    logic                      hsync_i;
    logic                      vsync_i;
    pixel_t                    pixel_i;
    logic                      capture_i;
    logic                      busy_o;
    logic                      capture_done_o;
    logic                      overflow_o;
    logic [`VCAP_ID_W-1:0]     awid_o;
    addr_t                     awaddr_o;
    burst_len_t                awlen_o;
    logic [2:0]                awsize_o;
    logic [1:0]                awburst_o;
    logic                      awvalid_o;
    logic                      awready_i;
    word_t                     wdata_o;
    logic [`VCAP_WORD_W/8-1:0] wstrb_o;
    logic                      wlast_o;
    logic                      wvalid_o;
    logic                      wready_i;
    logic [1:0]                bresp_i;
    logic                      bvalid_i;
    logic                      bready_o;

    logic [31:0] stim [STIM_LINES*STIM_COLS];

    // Memory image of the frame region, indexed by word
    word_t mem_words [MEM_WORDS];
    logic  written [MEM_WORDS];
    int    burst_lens [MAX_BURSTS];

    int stall_mode   = 0;
    int capture_open = 0;
    int exp_words    = 0;
    int burst_cnt    = 0;
    int word_index   = 0;
    int beats_left   = 0;
    int pending_b    = 0;
    int done_count   = 0;
    int done_seen    = 0;

    vcap_top dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("** Error at %0t ns: %s", $time, what);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic accept_address();
        addr_t exp_addr;
        exp_addr = addr_t'(`VCAP_FRAME_BASE + burst_cnt * BURST_BYTES);
        assert (capture_open != 0)
            else report_failure("write address issued with no capture requested");
        assert (beats_left == 0)
            else report_failure("new write address before the previous burst ended");
        assert (burst_cnt < MAX_BURSTS) else report_failure("too many bursts for one frame");
        assert (awaddr_o == exp_addr) else report_mismatch("awaddr_o", awaddr_o, exp_addr);
        assert (awsize_o == 3'd2) else report_mismatch("awsize_o", awsize_o, 2);
        assert (awburst_o == 2'b01) else report_mismatch("awburst_o", awburst_o, 1);
        assert (awid_o == '0) else report_mismatch("awid_o", awid_o, 0);
        burst_lens[burst_cnt] = awlen_o;
        word_index = burst_cnt * `VCAP_BURST_LEN;
        beats_left = awlen_o + 1;
        burst_cnt++;
    endtask

    task automatic accept_beat();
        assert (beats_left > 0) else report_failure("write data beat with no open burst");
        assert (word_index < exp_words)
            else report_failure("write beyond the end of the captured frame");
        assert (!written[word_index]) else report_failure("frame word written twice");
        assert (wstrb_o == '1) else report_mismatch("wstrb_o", wstrb_o, 4'hf);
        assert (wlast_o == (beats_left == 1))
            else report_mismatch("wlast_o", wlast_o, beats_left == 1);
        mem_words[word_index] = wdata_o;
        written[word_index] = 1'b1;
        word_index++;
        beats_left--;
        if (beats_left == 0) begin
            pending_b++;
        end
    endtask

    // AXI slave that samples handshakes mid-cycle and drives ready and response after the edge
    initial begin : memory_model
        int mode;
        void'($urandom(32'he4bf_9006));
        mode      = 0;
        awready_i = 1'b0;
        wready_i  = 1'b0;
        bvalid_i  = 1'b0;
        bresp_i   = 2'b00;
        forever begin
            @(negedge clk);
            mode = stall_mode;
            if (awvalid_o && awready_i) begin
                accept_address();
            end
            if (wvalid_o && wready_i) begin
                accept_beat();
            end
            if (bvalid_i && bready_o) begin
                pending_b--;
            end
            if (capture_done_o) begin
                assert (pending_b == 0 && beats_left == 0 && !awvalid_o)
                    else report_failure("capture_done_o before every burst was answered");
                done_count++;
            end
            @(posedge clk);
            #1;
            case (mode)
                1: begin
                    awready_i = ($urandom % 2) == 0;
                    wready_i  = ($urandom % 8) != 0;
                end
                2: begin
                    awready_i = 1'b1;
                    wready_i  = 1'b0;
                end
                default: begin
                    awready_i = 1'b1;
                    wready_i  = 1'b1;
                end
            endcase
            if (pending_b == 0) begin
                bvalid_i = 1'b0;
            end else if (!bvalid_i) begin
                bvalid_i = (mode != 1) || (($urandom % 2) == 0);
            end
        end
    end

    task automatic send_frame(input int w, input int h, input int blank, input int base);
        int x;
        int y;
        int b;
        vsync_i = 1'b1;
        repeat (2) tick();
        vsync_i = 1'b0;
        for (y = 0; y < h; y++) begin
            for (b = 0; b < blank; b++) begin
                hsync_i = (b == 0);
                tick();
            end
            hsync_i = 1'b0;
            for (x = 0; x < w; x++) begin
                de_i    = 1'b1;
                pixel_i = pixel_t'(base + y * w + x);
                tick();
            end
            de_i = 1'b0;
        end
        repeat (blank) tick();
    endtask

    task automatic start_capture(input int w, input int h);
        int k;
        assert (!busy_o) else report_mismatch("busy_o", busy_o, 0);
        assert (w * h <= MEM_WORDS) else report_failure("stimulus frame too large");
        for (k = 0; k < MEM_WORDS; k++) begin
            written[k] = 1'b0;
        end
        exp_words    = w * h;
        burst_cnt    = 0;
        capture_open = 1;
        capture_i    = 1'b1;
        tick();
        capture_i = 1'b0;
        tick();
        assert (busy_o) else report_mismatch("busy_o", busy_o, 1);
    endtask

    // Second request while busy must not re-arm
    task automatic pulse_while_busy();
        assert (busy_o) else report_mismatch("busy_o", busy_o, 1);
        capture_i = 1'b1;
        tick();
        capture_i = 1'b0;
    endtask

    task automatic finish_capture(input int line);
        int    w;
        int    h;
        int    base;
        int    ovf;
        int    t;
        int    k;
        int    full;
        int    tail;
        int    exp_len;
        word_t exp_word;
        w    = stim[line*STIM_COLS];
        h    = stim[line*STIM_COLS+1];
        base = stim[line*STIM_COLS+3];
        ovf  = stim[line*STIM_COLS+6];
        t    = 0;
        while (done_count == done_seen && t < DONE_LIMIT) begin
            tick();
            t++;
        end
        assert (done_count != done_seen) else report_failure("timeout waiting for capture_done_o");
        repeat (20) tick();
        assert (done_count == done_seen + 1)
            else report_mismatch("capture_done_o pulse count", done_count - done_seen, 1);
        assert (!busy_o) else report_mismatch("busy_o", busy_o, 0);
        assert (overflow_o == (ovf != 0)) else report_mismatch("overflow_o", overflow_o, ovf);
        done_seen    = done_count;
        capture_open = 0;
        if (ovf == 0) begin
            full = (w * h) / `VCAP_BURST_LEN;
            tail = (w * h) % `VCAP_BURST_LEN;
            assert (burst_cnt == full + (tail != 0))
                else report_mismatch("burst count", burst_cnt, full + (tail != 0));
            for (k = 0; k < burst_cnt; k++) begin
                exp_len = (k == full) ? tail - 1 : `VCAP_BURST_LEN - 1;
                assert (burst_lens[k] == exp_len)
                    else report_mismatch("awlen_o", burst_lens[k], exp_len);
            end
            for (k = 0; k < w * h; k++) begin
                exp_word = word_t'((base + k) & 24'hff_ffff);
                assert (written[k])
                    else report_failure($sformatf("pixel %0d of the frame never written", k));
                assert (mem_words[k] == exp_word)
                    else report_mismatch($sformatf("memory[0x%08h]",
                                                   `VCAP_FRAME_BASE + 4 * k),
                                         mem_words[k], exp_word);
            end
        end
    endtask

    initial begin : main_flow
        int i;
        int k;
        int cap_line;
        rst_n_i    = 1'b0;
        de_i       = 1'b0;
        hsync_i    = 1'b0;
        vsync_i    = 1'b0;
        pixel_i    = '0;
        capture_i  = 1'b0;
        for (k = 0; k < STIM_LINES * STIM_COLS; k++) begin
            stim[k] = '0;
        end
        $readmemh("sim/vcap_stimulus.txt", stim);

        repeat (10) tick();
        rst_n_i = 1'b1;
        tick();
        assert (!awvalid_o) else report_mismatch("awvalid_o", awvalid_o, 0);
        assert (!wvalid_o) else report_mismatch("wvalid_o", wvalid_o, 0);
        assert (!bready_o) else report_mismatch("bready_o", bready_o, 0);
        assert (!busy_o) else report_mismatch("busy_o", busy_o, 0);
        assert (!capture_done_o) else report_mismatch("capture_done_o", capture_done_o, 0);
        assert (!overflow_o) else report_mismatch("overflow_o", overflow_o, 0);

        // A captured frame ends at the first pixel of the frame after it
        cap_line = -1;
        for (i = 0; i < STIM_LINES && stim[i*STIM_COLS] != 0; i++) begin
            k = i * STIM_COLS;
            stall_mode = stim[k+5];
            if (stim[k+4] != 0) begin
                assert (cap_line < 0)
                    else report_failure("captured frame in stimulus has no frame after it");
                start_capture(stim[k], stim[k+1]);
            end else if (cap_line >= 0) begin
                pulse_while_busy();
            end
            send_frame(stim[k], stim[k+1], stim[k+2], stim[k+3]);
            if (cap_line >= 0) begin
                finish_capture(cap_line);
                cap_line = -1;
            end
            if (stim[k+4] != 0) begin
                cap_line = i;
            end
        end
        assert (cap_line < 0) else report_failure("stimulus ends right after a captured frame");
        repeat (10) tick();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/vcap_stimulus.txt ====
// Columns, all hex: width height blanking pattern_base capture stall overflow
// Stall 0 memory always ready, 1 random ready, 2 wready low; a width of 0 ends the list
08 04 06 000100 0 0 0  // idle frame, memory must stay untouched
10 04 06 123456 1 0 0  // 64 pixels, whole bursts only
08 02 05 000200 0 0 0  // ends the capture above
0b 05 07 fffff0 1 1 0  // 55 pixels with a short tail, pattern wraps 24 bits
07 03 04 abcdef 0 1 0
05 03 04 200000 1 0 0  // single short burst
08 02 05 300000 0 0 0
14 06 08 400000 1 1 0  // random stalls over 120 pixels
08 02 05 500000 0 1 0
10 08 06 600000 1 2 1  // data FIFO overflows while wready is low
08 02 05 700000 0 0 0
00 00 00 000000 0 0 0

// ==== src/axi_burst_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vcap_defs.svh"

module axi_burst_writer (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire vcap_pkg::burst_cmd_t cmd_i,
    input  wire                       cmd_empty_i,
    output logic                      cmd_pop_o,
    input  wire vcap_pkg::word_t      data_i,
    input  wire                       data_empty_i,
    output logic                      data_pop_o,
    output logic                      burst_done_o,
    output logic [`VCAP_ID_W-1:0]     awid_o,
    output vcap_pkg::addr_t           awaddr_o,
    output vcap_pkg::burst_len_t      awlen_o,
    output logic [2:0]                awsize_o,
    output logic [1:0]                awburst_o,
    output logic                      awvalid_o,
    input  wire                       awready_i,
    output vcap_pkg::word_t           wdata_o,
    output logic [`VCAP_WORD_W/8-1:0] wstrb_o,
    output logic                      wlast_o,
    output logic                      wvalid_o,
    input  wire                       wready_i,
    input  wire [1:0]                 bresp_i,
    input  wire                       bvalid_i,
    output logic                      bready_o
);
    import vcap_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP
    } state_t;

    state_t     state;
    addr_t      addr_q;
    burst_len_t len_q;
    burst_len_t beat_cnt;

    assign cmd_pop_o = (state == S_IDLE) && !cmd_empty_i;

    // Single ID, full-width incrementing bursts
    assign awid_o    = '0;
    assign awaddr_o  = addr_q;
    assign awlen_o   = len_q;
    assign awsize_o  = 3'($clog2(`VCAP_WORD_W / 8));
    assign awburst_o = 2'b01;
    assign awvalid_o = (state == S_ADDR);

    // Only this block pops, so a non-empty head stays put until accepted
    assign wdata_o    = data_i;
    assign wstrb_o    = '1;
    assign wvalid_o   = (state == S_DATA) && !data_empty_i;
    assign wlast_o    = wvalid_o && (beat_cnt == len_q);
    assign data_pop_o = wvalid_o && wready_i;

    assign bready_o     = (state == S_RESP);
    assign burst_done_o = bready_o && bvalid_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= S_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    beat_cnt <= '0;
                    if (cmd_pop_o) begin
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (awready_i) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (data_pop_o) begin
                        if (wlast_o) begin
                            state <= S_RESP;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                S_RESP: begin
                    if (bvalid_i) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop_o) begin
            addr_q <= cmd_i.addr;
            len_q  <= cmd_i.len;
        end
    end

endmodule

`default_nettype wire

// ==== src/frame_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vcap_defs.svh"

module frame_capture (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  capture_i,
    vcap_stream_if.sink          strm,
    output logic                 data_push_o,
    output vcap_pkg::word_t      data_o,
    input  wire                  data_full_i,
    output logic                 cmd_push_o,
    output vcap_pkg::burst_cmd_t cmd_o,
    input  wire                  cmd_full_i,
    input  wire                  burst_done_i,
    output logic                 busy_o,
    output logic                 capture_done_o,
    output logic                 overflow_o
);
    import vcap_pkg::*;

    localparam burst_len_t LAST_WORD = burst_len_t'(`VCAP_BURST_LEN - 1);
    localparam addr_t BURST_BYTES = addr_t'(`VCAP_BURST_LEN * (`VCAP_WORD_W / 8));
    localparam int OUTST_W = $clog2(`VCAP_CMD_DEPTH + 2);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ARMED,
        S_CAPTURING,
        S_DRAINING
    } state_t;

    state_t             state;
    burst_len_t         word_cnt;
    addr_t              burst_addr;
    logic [OUTST_W-1:0] outstanding;
    logic               take;
    logic               room;
    logic               full_burst;
    logic               tail_push;

    // Video cannot stall
    assign strm.tready = 1'b1;

    // Frame runs from one tuser pixel up to the next
    assign take = strm.tvalid &&
                  ((state == S_ARMED && strm.tuser) ||
                   (state == S_CAPTURING && !strm.tuser));

    // The word that closes a burst also needs a command slot
    assign room       = !data_full_i && !(word_cnt == LAST_WORD && cmd_full_i);
    assign full_burst = data_push_o && (word_cnt == LAST_WORD);
    assign tail_push  = (state == S_DRAINING) && (word_cnt != '0) && !cmd_full_i;

    assign data_push_o = take && room;
    assign data_o      = word_t'(strm.tdata);
    assign cmd_push_o  = full_burst || tail_push;
    assign busy_o      = (state != S_IDLE);

    always_comb begin
        cmd_o.addr = burst_addr;
        cmd_o.len  = tail_push ? word_cnt - 1'b1 : LAST_WORD;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state          <= S_IDLE;
            word_cnt       <= '0;
            burst_addr     <= '0;
            outstanding    <= '0;
            capture_done_o <= 1'b0;
            overflow_o     <= 1'b0;
        end else begin
            capture_done_o <= 1'b0;

            if (take && !room) begin
                overflow_o <= 1'b1;
            end

            if (full_burst || tail_push) begin
                word_cnt <= '0;
            end else if (data_push_o) begin
                word_cnt <= word_cnt + 1'b1;
            end

            if (full_burst) begin
                burst_addr <= burst_addr + BURST_BYTES;
            end

            // Bursts handed to the writer and not yet answered
            if (cmd_push_o && !burst_done_i) begin
                outstanding <= outstanding + 1'b1;
            end else if (!cmd_push_o && burst_done_i) begin
                outstanding <= outstanding - 1'b1;
            end

            case (state)
                S_IDLE: begin
                    if (capture_i) begin
                        state      <= S_ARMED;
                        burst_addr <= `VCAP_FRAME_BASE;
                    end
                end
                S_ARMED: begin
                    if (strm.tvalid && strm.tuser) begin
                        state <= S_CAPTURING;
                    end
                end
                S_CAPTURING: begin
                    if (strm.tvalid && strm.tuser) begin
                        state <= S_DRAINING;
                    end
                end
                S_DRAINING: begin
                    if (word_cnt == '0 && outstanding == '0) begin
                        state          <= S_IDLE;
                        capture_done_o <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/vcap_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module vcap_fifo #(
    parameter type T = logic [31:0],
    parameter int DEPTH = 16
) (
    input  wire   clk,
    input  wire   rst_n_i,
    input  wire   push_i,
    input  wire T din_i,
    output logic  full_o,
    input  wire   pop_i,
    output T      dout_o,
    output logic  empty_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign full_o  = (count == CNT_W'(DEPTH));
    assign empty_o = (count == '0);
    assign dout_o  = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/vcap_pkg.sv ====
`default_nettype none

`include "vcap_defs.svh"

package vcap_pkg;

    typedef logic [`VCAP_PIXEL_W-1:0] pixel_t;
    typedef logic [`VCAP_WORD_W-1:0] word_t;
    typedef logic [`VCAP_ADDR_W-1:0] addr_t;

    // Same encoding as AXI awlen
    typedef logic [7:0] burst_len_t;

    // Length above address, as one 40 bit control word
    typedef struct packed {
        burst_len_t len;
        addr_t      addr;
    } burst_cmd_t;

endpackage

`default_nettype wire

// ==== src/vcap_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface vcap_stream_if;
    import vcap_pkg::*;

    pixel_t tdata;
    logic   tvalid;
    logic   tready;
    // Start of frame
    logic   tuser;
    // End of line
    logic   tlast;

    modport source (
        output tdata,
        output tvalid,
        output tuser,
        output tlast,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tvalid,
        input  tuser,
        input  tlast,
        output tready
    );

endinterface

`default_nettype wire

// ==== src/vcap_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vcap_defs.svh"

module vcap_top (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire                       de_i,
    input  wire                       hsync_i,
    input  wire                       vsync_i,
    input  wire vcap_pkg::pixel_t     pixel_i,
    input  wire                       capture_i,
    output logic                      busy_o,
    output logic                      capture_done_o,
    output logic                      overflow_o,
    output logic [`VCAP_ID_W-1:0]     awid_o,
    output vcap_pkg::addr_t           awaddr_o,
    output vcap_pkg::burst_len_t      awlen_o,
    output logic [2:0]                awsize_o,
    output logic [1:0]                awburst_o,
    output logic                      awvalid_o,
    input  wire                       awready_i,
    output vcap_pkg::word_t           wdata_o,
    output logic [`VCAP_WORD_W/8-1:0] wstrb_o,
    output logic                      wlast_o,
    output logic                      wvalid_o,
    input  wire                       wready_i,
    input  wire [1:0]                 bresp_i,
    input  wire                       bvalid_i,
    output logic                      bready_o
);
    import vcap_pkg::*;

    vcap_stream_if strm ();

    word_t      data_in;
    logic       data_push;
    logic       data_full;
    logic       data_pop;
    word_t      data_head;
    logic       data_empty;
    burst_cmd_t cmd_in;
    logic       cmd_push;
    logic       cmd_full;
    logic       cmd_pop;
    burst_cmd_t cmd_head;
    logic       cmd_empty;
    logic       burst_done;

    video_stream_gen u_video_stream_gen (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .de_i    (de_i),
        .hsync_i (hsync_i),
        .vsync_i (vsync_i),
        .pixel_i (pixel_i),
        .strm    (strm.source)
    );

    frame_capture u_frame_capture (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .capture_i      (capture_i),
        .strm           (strm.sink),
        .data_push_o    (data_push),
        .data_o         (data_in),
        .data_full_i    (data_full),
        .cmd_push_o     (cmd_push),
        .cmd_o          (cmd_in),
        .cmd_full_i     (cmd_full),
        .burst_done_i   (burst_done),
        .busy_o         (busy_o),
        .capture_done_o (capture_done_o),
        .overflow_o     (overflow_o)
    );

    vcap_fifo #(.T(word_t), .DEPTH(`VCAP_DATA_DEPTH)) u_data_fifo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .push_i  (data_push),
        .din_i   (data_in),
        .full_o  (data_full),
        .pop_i   (data_pop),
        .dout_o  (data_head),
        .empty_o (data_empty)
    );

    vcap_fifo #(.T(burst_cmd_t), .DEPTH(`VCAP_CMD_DEPTH)) u_cmd_fifo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .push_i  (cmd_push),
        .din_i   (cmd_in),
        .full_o  (cmd_full),
        .pop_i   (cmd_pop),
        .dout_o  (cmd_head),
        .empty_o (cmd_empty)
    );

    axi_burst_writer u_axi_burst_writer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .cmd_i        (cmd_head),
        .cmd_empty_i  (cmd_empty),
        .cmd_pop_o    (cmd_pop),
        .data_i       (data_head),
        .data_empty_i (data_empty),
        .data_pop_o   (data_pop),
        .burst_done_o (burst_done),
        .awid_o       (awid_o),
        .awaddr_o     (awaddr_o),
        .awlen_o      (awlen_o),
        .awsize_o     (awsize_o),
        .awburst_o    (awburst_o),
        .awvalid_o    (awvalid_o),
        .awready_i    (awready_i),
        .wdata_o      (wdata_o),
        .wstrb_o      (wstrb_o),
        .wlast_o      (wlast_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready_i),
        .bresp_i      (bresp_i),
        .bvalid_i     (bvalid_i),
        .bready_o     (bready_o)
    );

endmodule

`default_nettype wire

// ==== src/video_stream_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_stream_gen (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   de_i,
    input  wire                   hsync_i,
    input  wire                   vsync_i,
    input  wire vcap_pkg::pixel_t pixel_i,
    vcap_stream_if.source         strm
);
    import vcap_pkg::*;

    pixel_t pix_q;
    logic   valid_q;
    logic   sof_q;
    logic   sof_armed;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q   <= 1'b0;
            sof_q     <= 1'b0;
            sof_armed <= 1'b0;
        end else begin
            valid_q <= de_i;
            if (de_i) begin
                sof_q <= sof_armed;
            end
            // Vsync arms the flag, first active pixel takes it
            if (vsync_i) begin
                sof_armed <= 1'b1;
            end else if (de_i) begin
                sof_armed <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (de_i) begin
            pix_q <= pixel_i;
        end
    end

    assign strm.tvalid = valid_q;
    assign strm.tdata  = pix_q;
    assign strm.tuser  = valid_q && sof_q;

    // Held pixel ends the line when de drops, or early on a stray hsync
    assign strm.tlast  = valid_q && (!de_i || hsync_i);

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
src/vcap_pkg.sv
src/vcap_stream_if.sv
src/vcap_fifo.sv
src/video_stream_gen.sv
src/frame_capture.sv
src/axi_burst_writer.sv
src/vcap_top.sv
sim/tb_vcap_top.sv
